// ==== common/rs_alu_pkg.sv ====
package rs_alu_pkg;

   localparam int DATA_LEN        = 32;
   localparam int ADDR_LEN        = 32;
   localparam int RRF_SEL         = 6;
   localparam int SPECTAG_LEN     = 5;
   localparam int ALU_OP_WIDTH    = 4;
   localparam int SRC_A_SEL_WIDTH = 2;
   localparam int SRC_B_SEL_WIDTH = 2;
   localparam int ALU_ENT_NUM     = 8;
   localparam int ALU_ENT_SEL     = 3;
   localparam int NUM_EXBUS       = 2;

   typedef logic [DATA_LEN-1:0]        data_t;
   typedef logic [ADDR_LEN-1:0]        addr_t;
   typedef logic [RRF_SEL-1:0]         rrf_tag_t;
   // one-hot branch tag
   typedef logic [SPECTAG_LEN-1:0]     spectag_t;
   typedef logic [ALU_OP_WIDTH-1:0]    alu_op_t;
   typedef logic [SRC_A_SEL_WIDTH-1:0] src_a_sel_t;
   typedef logic [SRC_B_SEL_WIDTH-1:0] src_b_sel_t;
   typedef logic [ALU_ENT_SEL-1:0]     ent_addr_t;
   typedef logic [ALU_ENT_NUM-1:0]     ent_vec_t;

   // operand word holds the value once valid
   // while still waiting it holds the producer's rename tag in the low bits
   typedef union packed {
      data_t value;
      struct packed {
         logic [DATA_LEN-RRF_SEL-1:0] pad;
         rrf_tag_t                    rrftag;
      } tag;
   } operand_u;

endpackage

// ==== common/rs_alu_if.sv ====
`timescale 1ns/1ns

// one dispatch slot into the station
interface alloc_if import rs_alu_pkg::*; ();
   logic       we;
   ent_addr_t  addr;
   addr_t      pc;
   operand_u   src1;
   operand_u   src2;
   logic       valid1;
   logic       valid2;
   data_t      imm;
   rrf_tag_t   rrftag;
   logic       dstval;
   src_a_sel_t src_a;
   src_b_sel_t src_b;
   alu_op_t    alu_op;
   spectag_t   spectag;
   logic       specbit;

   // control side only needs the strobe, target and spec bit
   modport sink (
      input we, addr, specbit
   );

   modport payload (
      input pc, src1, src2, valid1, valid2, imm, rrftag, dstval,
      input src_a, src_b, alu_op, spectag
   );
endinterface

// execution result broadcast
interface exbus_if import rs_alu_pkg::*; ();
   data_t    [NUM_EXBUS-1:0] exrslt;
   rrf_tag_t [NUM_EXBUS-1:0] exdst;
   logic     [NUM_EXBUS-1:0] kill_spec;

   modport listen (
      input exrslt, exdst, kill_spec
   );
endinterface

// ==== verilog/src_manager.sv ====
`timescale 1ns/1ns

module src_manager import rs_alu_pkg::*; (
   input  operand_u opr,
   input  logic     opr_rdy,
   exbus_if.listen  exbus,
   output operand_u src,
   output logic     resolved
);

   always_comb begin
      src      = opr;
      resolved = opr_rdy;
      // waiting operand snoops every live result bus
      if (!opr_rdy) begin
         for (int i = 0; i < NUM_EXBUS; i++) begin
            if (!exbus.kill_spec[i] && exbus.exdst[i] == opr.tag.rrftag) begin
               src.value = exbus.exrslt[i];
               resolved  = 1'b1;
            end
         end
      end
   end

endmodule

// ==== rs_alu/rs_alu_ent.sv ====
`timescale 1ns/1ns

module rs_alu_ent import rs_alu_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic       we,
   input  logic       sel2,
   alloc_if.payload   alloc_1,
   alloc_if.payload   alloc_2,
   exbus_if.listen    exbus,
   output addr_t      pc,
   output data_t      imm,
   output rrf_tag_t   rrftag,
   output logic       dstval,
   output src_a_sel_t src_a,
   output src_b_sel_t src_b,
   output alu_op_t    alu_op,
   output spectag_t   spectag,
   output data_t      ex_src1,
   output data_t      ex_src2,
   output logic       opr_rdy
);
   operand_u src1;
   operand_u src2;
   operand_u nxt_src1;
   operand_u nxt_src2;
   logic     valid1;
   logic     valid2;
   logic     nxt_valid1;
   logic     nxt_valid2;

   src_manager srcmng1 (
      .opr(src1),
      .opr_rdy(valid1),
      .exbus(exbus),
      .src(nxt_src1),
      .resolved(nxt_valid1)
   );

   src_manager srcmng2 (
      .opr(src2),
      .opr_rdy(valid2),
      .exbus(exbus),
      .src(nxt_src2),
      .resolved(nxt_valid2)
   );

   // wakeup result already folded in, so a same-cycle broadcast forwards
   assign ex_src1 = nxt_src1.value;
   assign ex_src2 = nxt_src2.value;
   assign opr_rdy = valid1 & valid2;

   always_ff @(posedge clk) begin
      if (reset) begin
         pc      <= '0;
         imm     <= '0;
         rrftag  <= '0;
         dstval  <= 1'b0;
         src_a   <= '0;
         src_b   <= '0;
         alu_op  <= '0;
         spectag <= '0;
         src1    <= '0;
         src2    <= '0;
         valid1  <= 1'b0;
         valid2  <= 1'b0;
      end else if (we) begin
         pc      <= sel2 ? alloc_2.pc : alloc_1.pc;
         imm     <= sel2 ? alloc_2.imm : alloc_1.imm;
         rrftag  <= sel2 ? alloc_2.rrftag : alloc_1.rrftag;
         dstval  <= sel2 ? alloc_2.dstval : alloc_1.dstval;
         src_a   <= sel2 ? alloc_2.src_a : alloc_1.src_a;
         src_b   <= sel2 ? alloc_2.src_b : alloc_1.src_b;
         alu_op  <= sel2 ? alloc_2.alu_op : alloc_1.alu_op;
         spectag <= sel2 ? alloc_2.spectag : alloc_1.spectag;
         src1    <= sel2 ? alloc_2.src1 : alloc_1.src1;
         src2    <= sel2 ? alloc_2.src2 : alloc_1.src2;
         valid1  <= sel2 ? alloc_2.valid1 : alloc_1.valid1;
         valid2  <= sel2 ? alloc_2.valid2 : alloc_1.valid2;
      end else begin
         src1   <= nxt_src1;
         src2   <= nxt_src2;
         valid1 <= nxt_valid1;
         valid2 <= nxt_valid2;
      end
   end

endmodule

// ==== rs_alu/rs_alu_issue_read.sv ====
`timescale 1ns/1ns

module rs_alu_issue_read import rs_alu_pkg::*; (
   input  ent_addr_t                    issueaddr,
   input  data_t      [ALU_ENT_NUM-1:0] ent_ex_src1,
   input  data_t      [ALU_ENT_NUM-1:0] ent_ex_src2,
   input  addr_t      [ALU_ENT_NUM-1:0] ent_pc,
   input  data_t      [ALU_ENT_NUM-1:0] ent_imm,
   input  rrf_tag_t   [ALU_ENT_NUM-1:0] ent_rrftag,
   input  ent_vec_t                     ent_dstval,
   input  src_a_sel_t [ALU_ENT_NUM-1:0] ent_src_a,
   input  src_b_sel_t [ALU_ENT_NUM-1:0] ent_src_b,
   input  alu_op_t    [ALU_ENT_NUM-1:0] ent_alu_op,
   input  spectag_t   [ALU_ENT_NUM-1:0] ent_spectag,
   output data_t                        ex_src1,
   output data_t                        ex_src2,
   output addr_t                        pc,
   output data_t                        imm,
   output rrf_tag_t                     rrftag,
   output logic                         dstval,
   output src_a_sel_t                   src_a,
   output src_b_sel_t                   src_b,
   output alu_op_t                      alu_op,
   output spectag_t                     spectag
);

   // plain 8:1 muxes, no priority
   assign ex_src1 = ent_ex_src1[issueaddr];
   assign ex_src2 = ent_ex_src2[issueaddr];
   assign pc      = ent_pc[issueaddr];
   assign imm     = ent_imm[issueaddr];
   assign rrftag  = ent_rrftag[issueaddr];
   assign dstval  = ent_dstval[issueaddr];
   assign src_a   = ent_src_a[issueaddr];
   assign src_b   = ent_src_b[issueaddr];
   assign alu_op  = ent_alu_op[issueaddr];
   assign spectag = ent_spectag[issueaddr];

endmodule

// ==== rs_alu/rs_alu_ctrl.sv ====
`timescale 1ns/1ns

module rs_alu_ctrl import rs_alu_pkg::*; (
   input  logic                       clk,
   input  logic                       reset,
   alloc_if.sink                      alloc_1,
   alloc_if.sink                      alloc_2,
   input  logic                       prmiss,
   input  logic                       prsuccess,
   input  spectag_t                   prtag,
   input  spectag_t                   specfixtag,
   input  logic                       clearbusy,
   input  ent_addr_t                  issueaddr,
   input  spectag_t [ALU_ENT_NUM-1:0] ent_spectag,
   input  ent_vec_t                   ent_rdy,
   output ent_vec_t                   ent_we,
   output ent_vec_t                   ent_sel2,
   output ent_vec_t                   busyvec,
   output ent_vec_t                   ready,
   output logic                       specbit
);
   ent_vec_t specbitvec;
   ent_vec_t spec_clr;
   ent_vec_t miss_hit;
   ent_vec_t succ_hit;
   ent_vec_t hit_1;
   ent_vec_t hit_2;
   ent_vec_t busy_nxt;
   ent_vec_t spec_nxt;

   always_comb begin
      for (int i = 0; i < ALU_ENT_NUM; i++) begin
         miss_hit[i] = |(ent_spectag[i] & specfixtag);
         succ_hit[i] = ent_spectag[i] == prtag;
         hit_1[i]    = alloc_1.we && alloc_1.addr == ALU_ENT_SEL'(i);
         hit_2[i]    = alloc_2.we && alloc_2.addr == ALU_ENT_SEL'(i);
      end
   end

   // writes are dropped while a mispredict flushes
   assign ent_we   = (hit_1 | hit_2) & {ALU_ENT_NUM{~prmiss}};
   assign ent_sel2 = ~hit_1;

   assign spec_clr = specbitvec & ~succ_hit;
   // resolved branch is visible on the read port this cycle
   assign specbit  = prsuccess ? spec_clr[issueaddr] : specbitvec[issueaddr];
   assign ready    = busyvec & ent_rdy;

   always_comb begin
      busy_nxt = busyvec;
      spec_nxt = prsuccess ? spec_clr : specbitvec;
      if (clearbusy) begin
         busy_nxt[issueaddr] = 1'b0;
      end
      if (prmiss) begin
         busy_nxt = busy_nxt & ~miss_hit;
         spec_nxt = '0;
      end else begin
         if (alloc_1.we) begin
            busy_nxt[alloc_1.addr] = 1'b1;
            spec_nxt[alloc_1.addr] = alloc_1.specbit;
         end
         if (alloc_2.we) begin
            busy_nxt[alloc_2.addr] = 1'b1;
            spec_nxt[alloc_2.addr] = alloc_2.specbit;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         busyvec    <= '0;
         specbitvec <= '0;
      end else begin
         busyvec    <= busy_nxt;
         specbitvec <= spec_nxt;
      end
   end

   a_dual_alloc_addr: assert property (@(posedge clk) disable iff (reset)
      alloc_1.we && alloc_2.we |-> alloc_1.addr != alloc_2.addr);

   // dispatcher picks from busyvec, so it must never land on a live entry
   a_alloc_free: assert property (@(posedge clk) disable iff (reset)
      !(alloc_1.we && busyvec[alloc_1.addr]) && !(alloc_2.we && busyvec[alloc_2.addr]));

   a_clear_busy: assert property (@(posedge clk) disable iff (reset)
      clearbusy |-> busyvec[issueaddr]);

endmodule

// ==== rs_alu/rs_alu.sv ====
`timescale 1ns/1ns

module rs_alu import rs_alu_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic       prmiss,
   input  logic       prsuccess,
   input  spectag_t   prtag,
   input  spectag_t   specfixtag,
   input  logic       clearbusy,
   input  ent_addr_t  issueaddr,
   input  logic       we_1,
   input  ent_addr_t  waddr_1,
   input  addr_t      wpc_1,
   input  data_t      wsrc1_1,
   input  data_t      wsrc2_1,
   input  logic       wvalid1_1,
   input  logic       wvalid2_1,
   input  data_t      wimm_1,
   input  rrf_tag_t   wrrftag_1,
   input  logic       wdstval_1,
   input  src_a_sel_t wsrc_a_1,
   input  src_b_sel_t wsrc_b_1,
   input  alu_op_t    walu_op_1,
   input  spectag_t   wspectag_1,
   input  logic       wspecbit_1,
   input  logic       we_2,
   input  ent_addr_t  waddr_2,
   input  addr_t      wpc_2,
   input  data_t      wsrc1_2,
   input  data_t      wsrc2_2,
   input  logic       wvalid1_2,
   input  logic       wvalid2_2,
   input  data_t      wimm_2,
   input  rrf_tag_t   wrrftag_2,
   input  logic       wdstval_2,
   input  src_a_sel_t wsrc_a_2,
   input  src_b_sel_t wsrc_b_2,
   input  alu_op_t    walu_op_2,
   input  spectag_t   wspectag_2,
   input  logic       wspecbit_2,
   input  data_t      exrslt_0,
   input  rrf_tag_t   exdst_0,
   input  logic       kill_spec_0,
   input  data_t      exrslt_1,
   input  rrf_tag_t   exdst_1,
   input  logic       kill_spec_1,
   output ent_vec_t   busyvec,
   output ent_vec_t   ready,
   output data_t      ex_src1,
   output data_t      ex_src2,
   output addr_t      pc,
   output data_t      imm,
   output rrf_tag_t   rrftag,
   output logic       dstval,
   output src_a_sel_t src_a,
   output src_b_sel_t src_b,
   output alu_op_t    alu_op,
   output spectag_t   spectag,
   output logic       specbit
);
   ent_vec_t                     ent_we;
   ent_vec_t                     ent_sel2;
   ent_vec_t                     ent_rdy;
   ent_vec_t                     ent_dstval;
   spectag_t   [ALU_ENT_NUM-1:0] ent_spectag;
   data_t      [ALU_ENT_NUM-1:0] ent_ex_src1;
   data_t      [ALU_ENT_NUM-1:0] ent_ex_src2;
   addr_t      [ALU_ENT_NUM-1:0] ent_pc;
   data_t      [ALU_ENT_NUM-1:0] ent_imm;
   rrf_tag_t   [ALU_ENT_NUM-1:0] ent_rrftag;
   src_a_sel_t [ALU_ENT_NUM-1:0] ent_src_a;
   src_b_sel_t [ALU_ENT_NUM-1:0] ent_src_b;
   alu_op_t    [ALU_ENT_NUM-1:0] ent_alu_op;

   alloc_if alloc_1 ();
   alloc_if alloc_2 ();
   exbus_if exbus ();

   assign alloc_1.we      = we_1;
   assign alloc_1.addr    = waddr_1;
   assign alloc_1.pc      = wpc_1;
   assign alloc_1.src1    = wsrc1_1;
   assign alloc_1.src2    = wsrc2_1;
   assign alloc_1.valid1  = wvalid1_1;
   assign alloc_1.valid2  = wvalid2_1;
   assign alloc_1.imm     = wimm_1;
   assign alloc_1.rrftag  = wrrftag_1;
   assign alloc_1.dstval  = wdstval_1;
   assign alloc_1.src_a   = wsrc_a_1;
   assign alloc_1.src_b   = wsrc_b_1;
   assign alloc_1.alu_op  = walu_op_1;
   assign alloc_1.spectag = wspectag_1;
   assign alloc_1.specbit = wspecbit_1;

   assign alloc_2.we      = we_2;
   assign alloc_2.addr    = waddr_2;
   assign alloc_2.pc      = wpc_2;
   assign alloc_2.src1    = wsrc1_2;
   assign alloc_2.src2    = wsrc2_2;
   assign alloc_2.valid1  = wvalid1_2;
   assign alloc_2.valid2  = wvalid2_2;
   assign alloc_2.imm     = wimm_2;
   assign alloc_2.rrftag  = wrrftag_2;
   assign alloc_2.dstval  = wdstval_2;
   assign alloc_2.src_a   = wsrc_a_2;
   assign alloc_2.src_b   = wsrc_b_2;
   assign alloc_2.alu_op  = walu_op_2;
   assign alloc_2.spectag = wspectag_2;
   assign alloc_2.specbit = wspecbit_2;

   assign exbus.exrslt    = {exrslt_1, exrslt_0};
   assign exbus.exdst     = {exdst_1, exdst_0};
   assign exbus.kill_spec = {kill_spec_1, kill_spec_0};

   rs_alu_ctrl ctrl (
      .clk(clk), .reset(reset),
      .alloc_1(alloc_1), .alloc_2(alloc_2),
      .prmiss(prmiss), .prsuccess(prsuccess),
      .prtag(prtag), .specfixtag(specfixtag),
      .clearbusy(clearbusy), .issueaddr(issueaddr),
      .ent_spectag(ent_spectag), .ent_rdy(ent_rdy),
      .ent_we(ent_we), .ent_sel2(ent_sel2),
      .busyvec(busyvec), .ready(ready), .specbit(specbit)
   );

   for (genvar i = 0; i < ALU_ENT_NUM; i++) begin : g_ent
      rs_alu_ent ent (
         .clk(clk), .reset(reset),
         .we(ent_we[i]), .sel2(ent_sel2[i]),
         .alloc_1(alloc_1), .alloc_2(alloc_2), .exbus(exbus),
         .pc(ent_pc[i]), .imm(ent_imm[i]), .rrftag(ent_rrftag[i]),
         .dstval(ent_dstval[i]), .src_a(ent_src_a[i]), .src_b(ent_src_b[i]),
         .alu_op(ent_alu_op[i]), .spectag(ent_spectag[i]),
         .ex_src1(ent_ex_src1[i]), .ex_src2(ent_ex_src2[i]),
         .opr_rdy(ent_rdy[i])
      );
   end

   rs_alu_issue_read issue_read (
      .issueaddr(issueaddr),
      .ent_ex_src1(ent_ex_src1), .ent_ex_src2(ent_ex_src2),
      .ent_pc(ent_pc), .ent_imm(ent_imm), .ent_rrftag(ent_rrftag),
      .ent_dstval(ent_dstval), .ent_src_a(ent_src_a), .ent_src_b(ent_src_b),
      .ent_alu_op(ent_alu_op), .ent_spectag(ent_spectag),
      .ex_src1(ex_src1), .ex_src2(ex_src2), .pc(pc), .imm(imm),
      .rrftag(rrftag), .dstval(dstval), .src_a(src_a), .src_b(src_b),
      .alu_op(alu_op), .spectag(spectag)
   );

endmodule

// ==== dv/tb_rs_alu.sv ====
`timescale 1ns/1ns

module tb_rs_alu;
   import rs_alu_pkg::*;

   localparam int       NUM_TESTS  = 5;
   localparam int       TIMEOUT_NS = NUM_TESTS * 200;
   localparam rrf_tag_t WAKE_TAG   = 6'h2a;

   logic       clk = 1'b0;
   logic       reset;
   logic       prmiss;
   logic       prsuccess;
   spectag_t   prtag;
   spectag_t   specfixtag;
   logic       clearbusy;
   ent_addr_t  issueaddr;
   // index 0 drives port _1, index 1 drives port _2
   logic       we [2];
   ent_addr_t  waddr [2];
   addr_t      wpc [2];
   data_t      wsrc1 [2];
   data_t      wsrc2 [2];
   logic       wvalid1 [2];
   logic       wvalid2 [2];
   data_t      wimm [2];
   rrf_tag_t   wrrftag [2];
   logic       wdstval [2];
   src_a_sel_t wsrc_a [2];
   src_b_sel_t wsrc_b [2];
   alu_op_t    walu_op [2];
   spectag_t   wspectag [2];
   logic       wspecbit [2];
   data_t      exrslt [2];
   rrf_tag_t   exdst [2];
   logic       kill_spec [2];
   ent_vec_t   busyvec;
   ent_vec_t   ready;
   data_t      ex_src1;
   data_t      ex_src2;
   addr_t      pc;
   data_t      imm;
   rrf_tag_t   rrftag;
   logic       dstval;
   src_a_sel_t src_a;
   src_b_sel_t src_b;
   alu_op_t    alu_op;
   spectag_t   spectag;
   logic       specbit;

   // expected contents of each entry
   addr_t      exp_pc [ALU_ENT_NUM];
   data_t      exp_src1 [ALU_ENT_NUM];
   data_t      exp_src2 [ALU_ENT_NUM];
   logic       exp_valid1 [ALU_ENT_NUM];
   logic       exp_valid2 [ALU_ENT_NUM];
   data_t      exp_imm [ALU_ENT_NUM];
   rrf_tag_t   exp_rrftag [ALU_ENT_NUM];
   logic       exp_dstval [ALU_ENT_NUM];
   src_a_sel_t exp_src_a [ALU_ENT_NUM];
   src_b_sel_t exp_src_b [ALU_ENT_NUM];
   alu_op_t    exp_alu_op [ALU_ENT_NUM];
   spectag_t   exp_spectag [ALU_ENT_NUM];
   ent_vec_t   exp_busy;
   integer     seed;

   rs_alu dut_i (
      .we_1(we[0]), .we_2(we[1]), .waddr_1(waddr[0]), .waddr_2(waddr[1]),
      .wpc_1(wpc[0]), .wpc_2(wpc[1]), .wsrc1_1(wsrc1[0]), .wsrc1_2(wsrc1[1]),
      .wsrc2_1(wsrc2[0]), .wsrc2_2(wsrc2[1]),
      .wvalid1_1(wvalid1[0]), .wvalid1_2(wvalid1[1]),
      .wvalid2_1(wvalid2[0]), .wvalid2_2(wvalid2[1]),
      .wimm_1(wimm[0]), .wimm_2(wimm[1]), .wrrftag_1(wrrftag[0]), .wrrftag_2(wrrftag[1]),
      .wdstval_1(wdstval[0]), .wdstval_2(wdstval[1]),
      .wsrc_a_1(wsrc_a[0]), .wsrc_a_2(wsrc_a[1]), .wsrc_b_1(wsrc_b[0]), .wsrc_b_2(wsrc_b[1]),
      .walu_op_1(walu_op[0]), .walu_op_2(walu_op[1]),
      .wspectag_1(wspectag[0]), .wspectag_2(wspectag[1]),
      .wspecbit_1(wspecbit[0]), .wspecbit_2(wspecbit[1]),
      .exrslt_0(exrslt[0]), .exrslt_1(exrslt[1]), .exdst_0(exdst[0]), .exdst_1(exdst[1]),
      .kill_spec_0(kill_spec[0]), .kill_spec_1(kill_spec[1]),
      .*
   );

   always #2 clk = ~clk;

   initial begin
      #(TIMEOUT_NS);
      $display("watchdog expired after %0d ns before the tests finished", TIMEOUT_NS);
      $display("SIMULATION FAILED");
      $fatal(1, "timeout");
   end

   task automatic check_data(input string name, input data_t got, input data_t exp);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
         $display("SIMULATION FAILED");
         $fatal(1, "data mismatch on %s", name);
      end
   endtask

   task automatic check_vec(input string name, input ent_vec_t got, input ent_vec_t exp);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
         $display("SIMULATION FAILED");
         $fatal(1, "vector mismatch on %s", name);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
         $display("SIMULATION FAILED");
         $fatal(1, "bit mismatch on %s", name);
      end
   endtask

   function automatic ent_vec_t ready_model();
      ent_vec_t r;
      for (int i = 0; i < ALU_ENT_NUM; i++) begin
         r[i] = exp_busy[i] & exp_valid1[i] & exp_valid2[i];
      end
      return r;
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic init_inputs();
      reset      = 1'b1;
      prmiss     = 1'b0;
      prsuccess  = 1'b0;
      prtag      = '0;
      specfixtag = '0;
      clearbusy  = 1'b0;
      issueaddr  = '0;
      exp_busy   = '0;
      for (int p = 0; p < 2; p++) begin
         we[p]        = 1'b0;
         waddr[p]     = '0;
         wpc[p]       = '0;
         wsrc1[p]     = '0;
         wsrc2[p]     = '0;
         wvalid1[p]   = 1'b0;
         wvalid2[p]   = 1'b0;
         wimm[p]      = '0;
         wrrftag[p]   = '0;
         wdstval[p]   = 1'b0;
         wsrc_a[p]    = '0;
         wsrc_b[p]    = '0;
         walu_op[p]   = '0;
         wspectag[p]  = '0;
         wspecbit[p]  = 1'b0;
         exrslt[p]    = '0;
         exdst[p]     = '0;
         // idle buses are held killed
         kill_spec[p] = 1'b1;
      end
      for (int i = 0; i < ALU_ENT_NUM; i++) begin
         exp_pc[i]      = '0;
         exp_src1[i]    = '0;
         exp_src2[i]    = '0;
         exp_valid1[i]  = 1'b0;
         exp_valid2[i]  = 1'b0;
         exp_imm[i]     = '0;
         exp_rrftag[i]  = '0;
         exp_dstval[i]  = 1'b0;
         exp_src_a[i]   = '0;
         exp_src_b[i]   = '0;
         exp_alu_op[i]  = '0;
         exp_spectag[i] = '0;
      end
   endtask

   task automatic make_payload(input ent_addr_t a, input logic v1, input logic v2,
                               input spectag_t st);
      exp_pc[a]      = $random(seed);
      exp_src1[a]    = $random(seed);
      exp_src2[a]    = $random(seed);
      exp_imm[a]     = $random(seed);
      exp_rrftag[a]  = rrf_tag_t'($random(seed));
      exp_dstval[a]  = 1'($random(seed));
      exp_src_a[a]   = src_a_sel_t'($random(seed));
      exp_src_b[a]   = src_b_sel_t'($random(seed));
      exp_alu_op[a]  = alu_op_t'($random(seed));
      exp_valid1[a]  = v1;
      exp_valid2[a]  = v2;
      exp_spectag[a] = st;
   endtask

   task automatic drive_alloc(input int p, input ent_addr_t a, input logic sb);
      we[p]       = 1'b1;
      waddr[p]    = a;
      wpc[p]      = exp_pc[a];
      wsrc1[p]    = exp_src1[a];
      wsrc2[p]    = exp_src2[a];
      wvalid1[p]  = exp_valid1[a];
      wvalid2[p]  = exp_valid2[a];
      wimm[p]     = exp_imm[a];
      wrrftag[p]  = exp_rrftag[a];
      wdstval[p]  = exp_dstval[a];
      wsrc_a[p]   = exp_src_a[a];
      wsrc_b[p]   = exp_src_b[a];
      walu_op[p]  = exp_alu_op[a];
      wspectag[p] = exp_spectag[a];
      wspecbit[p] = sb;
   endtask

   task automatic drop_alloc();
      we[0] = 1'b0;
      we[1] = 1'b0;
   endtask

   // each check below is entered 1 ns after an edge and uses up one cycle
   task automatic check_status();
      @(negedge clk);
      check_vec("busyvec", busyvec, exp_busy);
      check_vec("ready", ready, ready_model());
      next_cycle();
   endtask

   task automatic check_entry(input ent_addr_t a);
      issueaddr = a;
      @(negedge clk);
      check_data($sformatf("pc[%0d]", a), pc, exp_pc[a]);
      check_data($sformatf("ex_src1[%0d]", a), ex_src1, exp_src1[a]);
      check_data($sformatf("ex_src2[%0d]", a), ex_src2, exp_src2[a]);
      check_data($sformatf("imm[%0d]", a), imm, exp_imm[a]);
      check_data($sformatf("rrftag[%0d]", a), data_t'(rrftag), data_t'(exp_rrftag[a]));
      check_bit($sformatf("dstval[%0d]", a), dstval, exp_dstval[a]);
      check_data($sformatf("src_a[%0d]", a), data_t'(src_a), data_t'(exp_src_a[a]));
      check_data($sformatf("src_b[%0d]", a), data_t'(src_b), data_t'(exp_src_b[a]));
      check_data($sformatf("alu_op[%0d]", a), data_t'(alu_op), data_t'(exp_alu_op[a]));
      check_data($sformatf("spectag[%0d]", a), data_t'(spectag), data_t'(exp_spectag[a]));
      next_cycle();
   endtask

   task automatic check_specbit(input ent_addr_t a, input logic expv);
      issueaddr = a;
      @(negedge clk);
      check_bit($sformatf("specbit[%0d]", a), specbit, expv);
      next_cycle();
   endtask

   task automatic free_entry(input ent_addr_t a);
      issueaddr = a;
      clearbusy = 1'b1;
      next_cycle();
      clearbusy   = 1'b0;
      exp_busy[a] = 1'b0;
   endtask

   task automatic apply_reset();
      reset = 1'b1;
      repeat (8) @(posedge clk);
      #1;
      reset = 1'b0;
      check_status();
      check_entry(3'd0);
   endtask

   task automatic test_single_alloc();
      make_payload(3'd3, 1'b1, 1'b1, 5'b00001);
      drive_alloc(0, 3'd3, 1'b0);
      next_cycle();
      drop_alloc();
      exp_busy[3] = 1'b1;
      check_status();
      check_entry(3'd3);
      free_entry(3'd3);
      check_status();
   endtask

   task automatic test_dual_alloc();
      make_payload(3'd1, 1'b1, 1'b1, 5'b00010);
      make_payload(3'd5, 1'b1, 1'b1, 5'b00100);
      drive_alloc(0, 3'd1, 1'b0);
      drive_alloc(1, 3'd5, 1'b0);
      next_cycle();
      drop_alloc();
      exp_busy[1] = 1'b1;
      exp_busy[5] = 1'b1;
      check_status();
      check_entry(3'd1);
      check_entry(3'd5);
      // miss with an empty mask, so only the dropped write matters
      make_payload(3'd2, 1'b1, 1'b1, 5'b00001);
      prmiss     = 1'b1;
      specfixtag = '0;
      drive_alloc(0, 3'd2, 1'b0);
      next_cycle();
      prmiss = 1'b0;
      drop_alloc();
      check_status();
      free_entry(3'd1);
      free_entry(3'd5);
      check_status();
   endtask

   task automatic test_wakeup();
      data_t rslt;
      make_payload(3'd4, 1'b1, 1'b0, 5'b01000);
      exp_src2[4] = {exp_src2[4][DATA_LEN-1:RRF_SEL], WAKE_TAG};
      drive_alloc(0, 3'd4, 1'b0);
      next_cycle();
      drop_alloc();
      exp_busy[4] = 1'b1;
      check_status();
      rslt = $random(seed);
      issueaddr    = 3'd4;
      exdst[1]     = WAKE_TAG;
      exrslt[1]    = rslt;
      kill_spec[1] = 1'b1;
      @(negedge clk);
      check_data("ex_src2 killed", ex_src2, exp_src2[4]);
      next_cycle();
      check_status();
      kill_spec[1] = 1'b0;
      @(negedge clk);
      check_data("ex_src2 forwarded", ex_src2, rslt);
      check_vec("ready", ready, ready_model());
      next_cycle();
      kill_spec[1] = 1'b1;
      exp_valid2[4] = 1'b1;
      exp_src2[4]   = rslt;
      check_status();
      check_entry(3'd4);
      free_entry(3'd4);
      check_status();
   endtask

   task automatic test_branch_miss();
      spectag_t mask;
      mask = 5'b00110;
      for (int i = 0; i < 4; i++) begin
         make_payload(ent_addr_t'(i), 1'b1, 1'b1, spectag_t'(1 << i));
      end
      drive_alloc(0, 3'd0, 1'b1);
      drive_alloc(1, 3'd1, 1'b1);
      next_cycle();
      drive_alloc(0, 3'd2, 1'b1);
      drive_alloc(1, 3'd3, 1'b1);
      next_cycle();
      drop_alloc();
      exp_busy[3:0] = 4'hf;
      check_status();
      prmiss     = 1'b1;
      specfixtag = mask;
      next_cycle();
      prmiss     = 1'b0;
      specfixtag = '0;
      // tags 00010 and 00100 fall under the mask
      exp_busy[1] = 1'b0;
      exp_busy[2] = 1'b0;
      check_status();
      free_entry(3'd0);
      free_entry(3'd3);
      check_status();
   endtask

   task automatic test_branch_success();
      make_payload(3'd6, 1'b1, 1'b1, 5'b00001);
      make_payload(3'd7, 1'b1, 1'b1, 5'b10000);
      drive_alloc(0, 3'd6, 1'b1);
      drive_alloc(1, 3'd7, 1'b1);
      next_cycle();
      drop_alloc();
      exp_busy[6] = 1'b1;
      exp_busy[7] = 1'b1;
      check_specbit(3'd6, 1'b1);
      check_specbit(3'd7, 1'b1);
      prsuccess = 1'b1;
      prtag     = 5'b00001;
      issueaddr = 3'd6;
      @(negedge clk);
      check_bit("specbit[6] during success", specbit, 1'b0);
      next_cycle();
      prsuccess = 1'b0;
      prtag     = '0;
      check_specbit(3'd6, 1'b0);
      check_specbit(3'd7, 1'b1);
      free_entry(3'd6);
      free_entry(3'd7);
      check_status();
   endtask

   initial begin
      seed = 32'h64eb_1279;
      init_inputs();
      apply_reset();
      test_single_alloc();
      test_dual_alloc();
      test_wakeup();
      test_branch_miss();
      test_branch_success();
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

// ==== vlog.f ====
common/rs_alu_pkg.sv
common/rs_alu_if.sv
verilog/src_manager.sv
rs_alu/rs_alu_ent.sv
rs_alu/rs_alu_issue_read.sv
rs_alu/rs_alu_ctrl.sv
rs_alu/rs_alu.sv
dv/tb_rs_alu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_rs_alu
FILELIST  := vlog.f
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP)
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := SIMULATION PASSED
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
